// ==== design/draw_sprite.sv ====
// Output lags the raster input by three cycles and needs xpos, ypos, rgb_in steady that long
`timescale 1ns/1ns

module draw_sprite (
    input  logic                     pclk,
    input  logic                     rst,
    input  sprite_pkg::pos_t         xpos,
    input  sprite_pkg::pos_t         ypos,
    input  vga_pkg::count_t          hcount_in,
    input  vga_pkg::count_t          vcount_in,
    input  logic                     hsync_in,
    input  logic                     vsync_in,
    input  logic                     hblnk_in,
    input  logic                     vblnk_in,
    input  sprite_pkg::rgb_t         rgb_in,
    input  sprite_pkg::rgb_t         rgb_pixel,
    output vga_pkg::count_t          hcount_out,
    output vga_pkg::count_t          vcount_out,
    output logic                     hsync_out,
    output logic                     vsync_out,
    output logic                     hblnk_out,
    output logic                     vblnk_out,
    output sprite_pkg::rgb_t         rgb_out,
    output sprite_pkg::sprite_addr_t pixel_addr
);

    import vga_pkg::*;
    import sprite_pkg::*;

    count_t       cnt_in [2];
    count_t       cnt_dly [2];
    rgb_t         rgb_dly;
    logic [3:0]   sync_dly;
    pos_t         col_diff;
    pos_t         row_diff;
    sprite_addr_t addr_nxt;
    rgb_t         rgb_nxt;

    // Extended by one bit so xpos + width cannot wrap
    function automatic logic in_sprite(input count_t h, input count_t v,
                                       input pos_t x, input pos_t y);
        logic [12:0] h_ext;
        logic [12:0] v_ext;
        logic [12:0] x_ext;
        logic [12:0] y_ext;
        h_ext = 13'(h);
        v_ext = 13'(v);
        x_ext = 13'(x);
        y_ext = 13'(y);
        return (h_ext >= x_ext) && (h_ext < x_ext + 13'(SPRITE_W)) &&
               (v_ext >= y_ext) && (v_ext < y_ext + 13'(SPRITE_H));
    endfunction

    ////////////////////////////////////////////////////////////
    // Decode stage, texel address
    ////////////////////////////////////////////////////////////

    always_comb begin
        col_diff = pos_t'(hcount_in) - xpos;
        row_diff = pos_t'(vcount_in) - ypos;
        addr_nxt = '0;
        if (in_sprite(hcount_in, vcount_in, xpos, ypos)) begin
            addr_nxt = {row_diff[COL_BITS-1:0], col_diff[COL_BITS-1:0]};
        end
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            pixel_addr <= '0;
        end else begin
            pixel_addr <= addr_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Raster delay, lines up with rgb_pixel
    ////////////////////////////////////////////////////////////

    assign cnt_in[0] = hcount_in;
    assign cnt_in[1] = vcount_in;

    for (genvar i = 0; i < 2; i++) begin : g_cnt_delay
        signal_delay #(.payload_t(count_t), .DEPTH(DRAW_DELAY)) u_cnt_delay (
            .pclk (pclk),
            .rst  (rst),
            .din  (cnt_in[i]),
            .dout (cnt_dly[i])
        );
    end

    signal_delay #(.payload_t(rgb_t), .DEPTH(DRAW_DELAY)) u_rgb_delay (
        .pclk (pclk),
        .rst  (rst),
        .din  (rgb_in),
        .dout (rgb_dly)
    );

    // Order is hsync, vsync, hblnk, vblnk
    signal_delay #(.payload_t(logic [3:0]), .DEPTH(DRAW_DELAY)) u_sync_delay (
        .pclk (pclk),
        .rst  (rst),
        .din  ({hsync_in, vsync_in, hblnk_in, vblnk_in}),
        .dout (sync_dly)
    );

    ////////////////////////////////////////////////////////////
    // Result stage, colour mix
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (sync_dly[1] || sync_dly[0]) begin
            rgb_nxt = '0;
        end else if (in_sprite(cnt_dly[0], cnt_dly[1], xpos, ypos)) begin
            rgb_nxt = rgb_pixel;
        end else begin
            rgb_nxt = rgb_dly;
        end
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= cnt_dly[0];
            vcount_out <= cnt_dly[1];
            hsync_out  <= sync_dly[3];
            vsync_out  <= sync_dly[2];
            hblnk_out  <= sync_dly[1];
            vblnk_out  <= sync_dly[0];
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

// ==== design/signal_delay.sv ====
// Fixed latency of DEPTH cycles, DEPTH must be at least one, all stages clear to zero on reset
`timescale 1ns/1ns

module signal_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     pclk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [DEPTH];

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            // Shift towards the output
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

// ==== design/sprite_display.sv ====
// Outputs trail the internal raster by three cycles, position and background are not frame-synced
`timescale 1ns/1ns

module sprite_display (
    input  logic             pclk,
    input  logic             rst,
    input  sprite_pkg::pos_t xpos,
    input  sprite_pkg::pos_t ypos,
    input  sprite_pkg::rgb_t bg_rgb,
    output vga_pkg::count_t  hcount,
    output vga_pkg::count_t  vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             hblnk,
    output logic             vblnk,
    output sprite_pkg::rgb_t rgb
);

    import vga_pkg::*;
    import sprite_pkg::*;

    // Raw raster from the timing generator
    count_t       tim_hcount;
    count_t       tim_vcount;
    logic         tim_hsync;
    logic         tim_vsync;
    logic         tim_hblnk;
    logic         tim_vblnk;
    sprite_addr_t pixel_addr;
    rgb_t         rgb_pixel;

    vga_timing u_vga_timing (
        .pclk   (pclk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    draw_sprite u_draw_sprite (
        .pclk       (pclk),
        .rst        (rst),
        .xpos       (xpos),
        .ypos       (ypos),
        .hcount_in  (tim_hcount),
        .vcount_in  (tim_vcount),
        .hsync_in   (tim_hsync),
        .vsync_in   (tim_vsync),
        .hblnk_in   (tim_hblnk),
        .vblnk_in   (tim_vblnk),
        .rgb_in     (bg_rgb),
        .rgb_pixel  (rgb_pixel),
        .hcount_out (hcount),
        .vcount_out (vcount),
        .hsync_out  (hsync),
        .vsync_out  (vsync),
        .hblnk_out  (hblnk),
        .vblnk_out  (vblnk),
        .rgb_out    (rgb),
        .pixel_addr (pixel_addr)
    );

    sprite_rom u_sprite_rom (
        .pclk  (pclk),
        .addr  (pixel_addr),
        .texel (rgb_pixel)
    );

endmodule

// ==== design/sprite_pkg.sv ====
// Single 48x64 sprite in a 64x64 address space, 12-bit RGB with four bits per channel
package sprite_pkg;

    typedef logic [11:0] pos_t;
    typedef logic [11:0] rgb_t;

    // Row in the upper six bits, column in the lower six
    localparam int COL_BITS = 6;
    typedef logic [COL_BITS-1:0] coord_t;
    typedef logic [2*COL_BITS-1:0] sprite_addr_t;

    localparam int SPRITE_W = 48;
    localparam int SPRITE_H = 64;

    // Raster delay that lines the counters up with the ROM word
    localparam int DRAW_DELAY = 2;

    // Red from the row, green from the column, blue a coarse checker
    function automatic rgb_t sprite_texel(input coord_t row, input coord_t col);
        logic [3:0] blue;
        blue = {2'b00, row[5:4] ^ col[5:4]};
        return {row[3:0], col[3:0], blue};
    endfunction

endpackage

// ==== design/sprite_rom.sv ====
// One-cycle read latency, contents fixed at start by the texel rule, no reset on the output
`timescale 1ns/1ns

module sprite_rom (
    input  logic                     pclk,
    input  sprite_pkg::sprite_addr_t addr,
    output sprite_pkg::rgb_t         texel
);

    import sprite_pkg::*;

    rgb_t mem [2**$bits(sprite_addr_t)];

    // Columns past the sprite width stay black
    initial begin
        for (int row = 0; row < SPRITE_H; row++) begin
            for (int col = 0; col < 2**COL_BITS; col++) begin
                if (col < SPRITE_W) begin
                    mem[{coord_t'(row), coord_t'(col)}] = sprite_texel(coord_t'(row),
                                                                       coord_t'(col));
                end else begin
                    mem[{coord_t'(row), coord_t'(col)}] = '0;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        texel <= mem[addr];
    end

endmodule

// ==== design/vga_pkg.sv ====
// Fixed 800x600 at 60 Hz raster on a 40 MHz pixel clock, both syncs active high
package vga_pkg;

    ////////////////////////////////////////////////////////////
    // Counter type
    ////////////////////////////////////////////////////////////

    // Wide enough for the 1056 pixels of one line
    typedef logic [10:0] count_t;

    ////////////////////////////////////////////////////////////
    // Horizontal timing in pixels
    ////////////////////////////////////////////////////////////

    localparam count_t H_ACTIVE = 11'd800;
    localparam count_t H_FRONT  = 11'd40;
    localparam count_t H_SYNC   = 11'd128;
    localparam count_t H_TOTAL  = 11'd1056;

    // Sync window, first pixel in and first pixel out
    localparam count_t H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam count_t H_SYNC_END   = H_SYNC_START + H_SYNC;

    ////////////////////////////////////////////////////////////
    // Vertical timing in lines
    ////////////////////////////////////////////////////////////

    localparam count_t V_ACTIVE = 11'd600;
    localparam count_t V_FRONT  = 11'd1;
    localparam count_t V_SYNC   = 11'd4;
    localparam count_t V_TOTAL  = 11'd628;

    localparam count_t V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam count_t V_SYNC_END   = V_SYNC_START + V_SYNC;

endpackage

// ==== design/vga_timing.sv ====
// Free-running raster from reset, syncs and blanks are registered alongside the counters
`timescale 1ns/1ns

module vga_timing (
    input  logic            pclk,
    input  logic            rst,
    output vga_pkg::count_t hcount,
    output vga_pkg::count_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk
);

    import vga_pkg::*;

    count_t hcount_nxt;
    count_t vcount_nxt;

    ////////////////////////////////////////////////////////////
    // Counter wrap
    ////////////////////////////////////////////////////////////

    always_comb begin
        hcount_nxt = hcount + count_t'(1);
        vcount_nxt = vcount;
        if (hcount == H_TOTAL - count_t'(1)) begin
            hcount_nxt = '0;
            if (vcount == V_TOTAL - count_t'(1)) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + count_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    // Levels come from the next counter values so they move with the counters
    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblnk  <= (hcount_nxt >= H_ACTIVE);
            vblnk  <= (vcount_nxt >= V_ACTIVE);
            hsync  <= (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
            vsync  <= (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the sprite display testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module tb_sprite_display \
    -f tb.f --Mdir "$BUILD_DIR" -o sim_top
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

"./$BUILD_DIR/sim_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/clk_gen.sv ====
// Clock runs from time zero, reset is released on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic pclk,
    output logic rst
);

    initial begin
        pclk = 1'b0;
        forever begin
            #(PERIOD / 2) pclk = ~pclk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge pclk);
        @(negedge pclk);
        rst = 1'b0;
    end

endmodule

// ==== sim/tb_sprite_display.sv ====
// Outputs sampled on the falling edge, settings change only in vertical blanking, run of about seven frames
`timescale 1ns/1ns

module tb_sprite_display;

    import vga_pkg::*;
    import sprite_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 7;
    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int CYCLE_LIMIT  = (NUM_TESTS + 1) * FRAME_CYCLES + RESET_CYCLES;

    logic   pclk;
    logic   rst;
    pos_t   xpos;
    pos_t   ypos;
    rgb_t   bg_rgb;
    count_t hcount;
    count_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;

    // Comparer state
    string       test_name = "reset";
    logic        model_on  = 1'b0;
    count_t      mh;
    count_t      mv;
    int          set_gen   = 0;
    int          seen_gen  = 0;
    int          settle    = 0;
    int          errors    = 0;
    int          checks    = 0;
    int          hits      = 0;
    // Main process state
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          main_errors  = 0;
    int          cycles       = 0;
    logic [31:0] lfsr         = 32'h46dc_9567;

    clk_gen #(.PERIOD(40), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .pclk (pclk),
        .rst  (rst)
    );

    sprite_display dut0 (
        .pclk   (pclk),
        .rst    (rst),
        .xpos   (xpos),
        .ypos   (ypos),
        .bg_rgb (bg_rgb),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .rgb    (rgb)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic sprite_hit(input count_t h, input count_t v,
                                        input pos_t x, input pos_t y);
        return (int'(h) >= int'(x)) && (int'(h) < int'(x) + SPRITE_W) &&
               (int'(v) >= int'(y)) && (int'(v) < int'(y) + SPRITE_H);
    endfunction

    function automatic rgb_t ref_rgb(input count_t h, input count_t v, input logic hb,
                                     input logic vb, input pos_t x, input pos_t y,
                                     input rgb_t bg);
        int row;
        int col;
        if (hb || vb) begin
            return '0;
        end
        if (!sprite_hit(h, v, x, y)) begin
            return bg;
        end
        row = int'(v) - int'(y);
        col = int'(h) - int'(x);
        return sprite_texel(coord_t'(row), coord_t'(col));
    endfunction

    // Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks and process
    ////////////////////////////////////////////////////////////

    task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input count_t exp, input count_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic compare_outputs();
        logic hb;
        logic vb;
        hb = (mh >= H_ACTIVE);
        vb = (mv >= V_ACTIVE);
        check_count("hcount", mh, hcount);
        check_count("vcount", mv, vcount);
        check_bit("hblnk", hb, hblnk);
        check_bit("vblnk", vb, vblnk);
        check_bit("hsync", (mh >= H_SYNC_START) && (mh < H_SYNC_END), hsync);
        check_bit("vsync", (mv >= V_SYNC_START) && (mv < V_SYNC_END), vsync);
        if (set_gen != seen_gen) begin
            seen_gen = set_gen;
            settle   = 3;
        end
        if (settle > 0) begin
            settle--;
        end else begin
            check_rgb("rgb", ref_rgb(mh, mv, hb, vb, xpos, ypos, bg_rgb), rgb);
            if (!hb && !vb && sprite_hit(mh, mv, xpos, ypos)) begin
                hits++;
            end
        end
    endtask

    // Counter model starts at the first nonzero hcount
    always @(negedge pclk) begin
        if (!model_on && hcount == '0) begin
            check_count("vcount", '0, vcount);
            check_bit("hsync", 1'b0, hsync);
            check_bit("vsync", 1'b0, vsync);
            check_bit("hblnk", 1'b0, hblnk);
            check_bit("vblnk", 1'b0, vblnk);
            check_rgb("rgb", '0, rgb);
        end else if (!model_on) begin
            model_on = 1'b1;
            mh       = count_t'(1);
            mv       = '0;
            compare_outputs();
        end else begin
            if (mh == H_TOTAL - count_t'(1)) begin
                mh = '0;
                mv = (mv == V_TOTAL - count_t'(1)) ? '0 : mv + count_t'(1);
            end else begin
                mh = mh + count_t'(1);
            end
            compare_outputs();
        end
    end

    always @(posedge pclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic report_test(input string name, input int n_err);
        if (n_err == 0) begin
            tests_passed++;
            $display("test %-10s passed", name);
        end else begin
            tests_failed++;
            $display("test %-10s failed with %0d errors", name, n_err);
        end
    endtask

    task automatic wait_frame_start();
        @(negedge pclk);
        while (!(vcount == V_ACTIVE && hcount == '0)) begin
            @(negedge pclk);
        end
    endtask

    // Entered just after the rising edge that follows a frame start
    task automatic run_frame(input string name, input pos_t x, input pos_t y,
                             input rgb_t bg, input int exp_hits);
        int err0;
        int hit0;
        int local_err;
        local_err = 0;
        @(negedge pclk);
        xpos   = x;
        ypos   = y;
        bg_rgb = bg;
        set_gen++;
        @(posedge pclk);
        test_name = name;
        err0 = errors;
        hit0 = hits;
        wait_frame_start();
        @(posedge pclk);
        if (exp_hits >= 0 && hits - hit0 != exp_hits) begin
            $display("Mismatch %s sprite pixels: expected %0d, actual %0d",
                     name, exp_hits, hits - hit0);
            local_err = 1;
        end
        main_errors += local_err;
        report_test(name, errors - err0 + local_err);
    endtask

    initial begin
        int rx;
        int ry;
        int rc;
        xpos   = 12'hfff;
        ypos   = 12'hfff;
        bg_rgb = '0;
        while (!model_on) begin
            @(posedge pclk);
        end
        report_test("reset", errors);
        wait_frame_start();
        @(posedge pclk);
        run_frame("raster", 12'hfff, 12'hfff, 12'h5a3, 0);
        run_frame("fixed", 12'd100, 12'd50, 12'h248, SPRITE_W * SPRITE_H);
        for (int i = 0; i < 3; i++) begin
            take_bits(10, rx);
            take_bits(9, ry);
            take_bits(12, rc);
            // Last frame pushes the sprite past the right and bottom edges
            if (i == 2) begin
                take_bits(5, rx);
                take_bits(5, ry);
                rx = 760 + rx;
                ry = 545 + ry;
            end
            run_frame($sformatf("random_%0d", i), pos_t'(rx), pos_t'(ry), rgb_t'(rc), -1);
        end
        run_frame("blanking", 12'd780, 12'd570, 12'hfff,
                  (int'(H_ACTIVE) - 780) * (int'(V_ACTIVE) - 570));
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors + main_errors);
        if (errors + main_errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/vga_pkg.sv
design/sprite_pkg.sv
design/vga_timing.sv
design/signal_delay.sv
design/sprite_rom.sv
design/draw_sprite.sv
design/sprite_display.sv
sim/clk_gen.sv
sim/tb_sprite_display.sv
